/* build.f */
hw/rv_fetch_pkg.sv
hw/fetch_ctrl.sv
hw/instr_decoder.sv
hw/instr_fetch_top.sv
tests/imem_axil_model.sv
tests/tb_instr_fetch.sv

/* Bender.yml */
package:
  name: instr_fetch

sources:
  - hw/rv_fetch_pkg.sv
  - hw/fetch_ctrl.sv
  - hw/instr_decoder.sv
  - hw/instr_fetch_top.sv
  - target: test
    files:
      - tests/imem_axil_model.sv
      - tests/tb_instr_fetch.sv

/* tests/tb_instr_fetch.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_instr_fetch;

  import rv_fetch_pkg::*;

  localparam int TIMEOUT = 100;  // Cycles allowed per wait
  localparam int HOLD_CYCLES = 10;
  localparam int SEQ_LEN = 15;
  localparam logic [2:0] FETCH_PROT = 3'b100;  // AXI prot[2] marks an instruction access

  logic clk;
  logic rst;
  axil_ar_t m_ar;
  logic m_arready;
  axil_r_t m_r;
  logic m_rready;
  logic issue_valid;
  logic issue_ready;
  issue_t issue;
  redirect_t redirect;

  int errors;
  int tests;
  int ar_hs_count;
  logic [XLEN-1:0] last_ar_addr;

  // One encoding per opcode group stored from PC 0 upward
  logic [XLEN-1:0] seq_words [SEQ_LEN] = '{
    32'h003100B3, 32'h023100B3, 32'h00500093, 32'h40315093, 32'h00012083,
    32'h00312223, 32'h00209463, 32'h010000EF, 32'h00008067, 32'h123450B7,
    32'h00001097, 32'h300110F3, 32'h0FF0000F, 32'h00000073, 32'h00100073
  };
  rv_op_e seq_ops [SEQ_LEN] = '{
    OP_ADD, OP_MUL, OP_ADDI, OP_SRAI, OP_LW,
    OP_SW, OP_BNE, OP_JAL, OP_JALR, OP_LUI,
    OP_AUIPC, OP_CSRRW, OP_FENCE, OP_ECALL, OP_EBREAK
  };

  instr_fetch_top i_dut (
    .clk(clk),
    .rst(rst),
    .m_ar(m_ar),
    .m_arready(m_arready),
    .m_r(m_r),
    .m_rready(m_rready),
    .issue_valid(issue_valid),
    .issue_ready(issue_ready),
    .issue(issue),
    .redirect(redirect)
  );

  imem_axil_model i_mem (
    .clk(clk),
    .rst(rst),
    .ar(m_ar),
    .arready(m_arready),
    .r(m_r),
    .rready(m_rready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    if (m_ar.valid && m_arready) begin  // AR beat on this edge
      ar_hs_count = ar_hs_count + 1;
      last_ar_addr = m_ar.addr;
      check_value("m_ar.prot", 32'(FETCH_PROT), 32'(m_ar.prot));
    end
  end

  function automatic logic [XLEN-1:0] fill_word(input int idx);
    return {12'(idx), 5'd0, 3'b000, 5'd1, 7'b0010011};  // ADDI x1, x0, idx
  endfunction

  task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                             input logic [XLEN-1:0] actual);
    assert (actual === expected)
      else begin
        $display("FAILED %s expected %h got %h", name, expected, actual);
        errors++;
      end
  endtask

  task automatic fill_memory();
    int i;
    for (i = 0; i < 64; i++) i_mem.mem[i] = fill_word(i);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    rst = 1'b1;
    issue_ready = 1'b0;
    redirect = '0;
    repeat (2) begin
      @(posedge clk);
      #1;
      assert (!issue_valid)
        else begin
          $display("issue_valid was high during reset");
          errors++;
        end
      check_value("m_ar.valid", 32'd0, 32'(m_ar.valid));
      check_value("m_rready", 32'd0, 32'(m_rready));
    end
    rst = 1'b0;
    ar_hs_count = 0;
  endtask

  task automatic wait_issue(input logic [XLEN-1:0] pc);
    int cycles;
    cycles = 0;
    while (!issue_valid && cycles < TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    assert (issue_valid)
      else begin
        $display("Timeout: no instruction was issued for PC %h", pc);
        errors++;
      end
  endtask

  // Waits for an issue, checks it, then accepts it with the given redirect
  task automatic take_issue(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] word,
                            input rv_op_e op, input logic taken,
                            input logic [XLEN-1:0] target);
    wait_issue(pc);
    if (issue_valid) begin
      check_value("issue.pc", pc, issue.pc);
      check_value("issue.word", word, issue.word);
      check_value("issue.op", 32'(op), 32'(issue.op));
      issue_ready = 1'b1;
      redirect = '{taken: taken, target: target};
      @(posedge clk);
      #1;
      issue_ready = 1'b0;
      redirect = '0;
    end
  endtask

  task automatic finish_test(input string name, input int start_errors);
    tests++;
    $display("%s finished with %0d errors", name, errors - start_errors);
  endtask

  task automatic reset_state();
    int start;
    int cycles;
    start = errors;
    fill_memory();
    apply_reset();
    @(posedge clk);
    #1;
    assert (!issue_valid)
      else begin
        $display("issue_valid was high in the first cycle after reset");
        errors++;
      end
    cycles = 0;
    while (ar_hs_count == 0 && cycles < TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    assert (ar_hs_count != 0)
      else begin
        $display("Timeout: no AR handshake after reset");
        errors++;
      end
    check_value("m_ar.addr", RESET_PC, last_ar_addr);
    finish_test("reset_state", start);
  endtask

  task automatic sequential_decode();
    int start;
    int i;
    start = errors;
    fill_memory();
    for (i = 0; i < SEQ_LEN; i++) i_mem.mem[i] = seq_words[i];
    apply_reset();
    for (i = 0; i < SEQ_LEN; i++) begin
      take_issue(RESET_PC + 32'(4 * i), seq_words[i], seq_ops[i], 1'b0, '0);
    end
    finish_test("sequential", start);
  endtask

  task automatic illegal_encodings();
    int start;
    start = errors;
    fill_memory();
    i_mem.mem[0] = 32'h0000007F;  // Unused major opcode
    i_mem.mem[1] = 32'h043100B3;  // OP with funct7 0000010
    apply_reset();
    take_issue(RESET_PC, 32'h0000007F, OP_ILLEGAL, 1'b0, '0);
    take_issue(RESET_PC + 4, 32'h043100B3, OP_ILLEGAL, 1'b0, '0);
    finish_test("illegal", start);
  endtask

  task automatic back_pressure();
    int start;
    int i;
    int hs_before;
    issue_t held;
    start = errors;
    fill_memory();
    apply_reset();
    wait_issue(RESET_PC);
    held = issue;
    hs_before = ar_hs_count;
    for (i = 0; i < HOLD_CYCLES; i++) begin
      @(posedge clk);
      #1;
      assert (issue_valid)
        else begin
          $display("issue_valid dropped while issue_ready was low");
          errors++;
        end
      check_value("issue.pc", held.pc, issue.pc);
      check_value("issue.word", held.word, issue.word);
      check_value("issue.op", 32'(held.op), 32'(issue.op));
      check_value("ar_hs_count", 32'(hs_before), 32'(ar_hs_count));
      check_value("m_ar.valid", 32'd0, 32'(m_ar.valid));
      check_value("m_rready", 32'd0, 32'(m_rready));
    end
    take_issue(RESET_PC, fill_word(0), OP_ADDI, 1'b0, '0);
    take_issue(RESET_PC + 4, fill_word(1), OP_ADDI, 1'b0, '0);
    finish_test("back_pressure", start);
  endtask

  task automatic redirect_taken();
    int start;
    start = errors;
    fill_memory();
    i_mem.mem[40] = 32'hABCDE0B7;  // LUI at byte address 0xA0
    apply_reset();
    take_issue(RESET_PC, fill_word(0), OP_ADDI, 1'b1, 32'h0000_00A0);
    take_issue(32'h0000_00A0, 32'hABCDE0B7, OP_LUI, 1'b0, '0);
    take_issue(32'h0000_00A4, fill_word(41), OP_ADDI, 1'b0, '0);
    finish_test("redirect", start);
  endtask

  task automatic fetch_fault();
    int start;
    start = errors;
    fill_memory();
    apply_reset();
    take_issue(RESET_PC, fill_word(0), OP_ADDI, 1'b1, 32'h0000_00FC);
    take_issue(32'h0000_00FC, fill_word(63), OP_FETCH_FAULT, 1'b0, '0);
    finish_test("fetch_fault", start);
  endtask

  initial begin
    rst = 1'b1;
    issue_ready = 1'b0;
    redirect = '0;
    errors = 0;
    tests = 0;
    ar_hs_count = 0;
    last_ar_addr = '0;
    reset_state();
    sequential_decode();
    illegal_encodings();
    back_pressure();
    redirect_taken();
    fetch_fault();
    $display("Tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tests/imem_axil_model.sv */
`timescale 1ns/10ps
`default_nettype none

module imem_axil_model (
  input wire logic clk,
  input wire logic rst,
  input wire rv_fetch_pkg::axil_ar_t ar,
  output logic arready,
  output rv_fetch_pkg::axil_r_t r,
  input wire logic rready
);

  import rv_fetch_pkg::*;

  localparam int WORDS = 64;
  localparam int ERR_WORD = 63;  // Byte address 32'h0000_00FC
  localparam logic [1:0] RESP_SLVERR = 2'b10;
  localparam logic [31:0] SEED = 32'h5c6349d2;

  logic [XLEN-1:0] mem [WORDS];
  logic ar_hs;
  logic r_hs;
  logic [XLEN-1:0] hs_addr;
  logic pending;  // Address taken but data not yet returned
  logic [5:0] rd_idx;
  int ar_wait;
  int r_wait;

  initial begin
    void'($urandom(SEED));
    arready = 1'b0;
    r = '0;
    pending = 1'b0;
    rd_idx = '0;
    ar_wait = 0;
    r_wait = 0;
    forever begin
      @(posedge clk);
      ar_hs = ar.valid & arready;  // Values from before the edge
      r_hs = r.valid & rready;
      hs_addr = ar.addr;
      #1;
      if (rst) begin
        arready = 1'b0;
        r = '0;
        pending = 1'b0;
        ar_wait = $urandom % 4;
      end else begin
        if (ar_hs) begin
          arready = 1'b0;
          pending = 1'b1;
          rd_idx = hs_addr[7:2];
          r_wait = $urandom % 4;
        end
        if (r_hs) begin
          r = '0;
          pending = 1'b0;
          ar_wait = $urandom % 4;
        end
        if (!pending && ar.valid && !arready) begin
          if (ar_wait == 0) arready = 1'b1;
          else ar_wait--;
        end
        if (pending && !r.valid) begin
          // Data still returned on the error word
          if (r_wait == 0) r = '{
            valid: 1'b1,
            data: mem[rd_idx],
            resp: (rd_idx == ERR_WORD) ? RESP_SLVERR : RESP_OKAY
          };
          else r_wait--;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hw/instr_fetch_top.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_fetch_top (
  input wire logic clk,
  input wire logic rst,
  output rv_fetch_pkg::axil_ar_t m_ar,
  input wire logic m_arready,
  input wire rv_fetch_pkg::axil_r_t m_r,
  output logic m_rready,
  output logic issue_valid,
  input wire logic issue_ready,
  output rv_fetch_pkg::issue_t issue,
  input wire rv_fetch_pkg::redirect_t redirect
);

  import rv_fetch_pkg::*;

  fetch_word_t fetch;  // Sequencer to instruction register
  logic issue_accept;  // Issue handshake, computed once in the decoder

  fetch_ctrl i_fetch_ctrl (
    .clk(clk),
    .rst(rst),
    .ar(m_ar),
    .arready(m_arready),
    .r(m_r),
    .rready(m_rready),
    .fetch(fetch),
    .issue_accept(issue_accept),
    .redirect(redirect)
  );

  instr_decoder i_instr_decoder (
    .clk(clk),
    .rst(rst),
    .fetch(fetch),
    .issue_valid(issue_valid),
    .issue_ready(issue_ready),
    .issue(issue),
    .issue_accept(issue_accept)
  );

endmodule

`default_nettype wire

/* hw/instr_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_decoder (
  input wire logic clk,
  input wire logic rst,
  input wire rv_fetch_pkg::fetch_word_t fetch,
  output logic issue_valid,
  input wire logic issue_ready,
  output rv_fetch_pkg::issue_t issue,
  output logic issue_accept
);

  import rv_fetch_pkg::*;

  logic [XLEN-1:0] ir_word;
  logic [XLEN-1:0] ir_pc;
  rv_op_e ir_op;
  rv_op_e decoded_op;

  function automatic rv_op_e decode(input logic [XLEN-1:0] word);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [11:0] imm12;
    rv_op_e op;
    opcode = word[6:0];
    funct3 = word[14:12];
    funct7 = word[31:25];
    imm12 = word[31:20];
    op = OP_ILLEGAL;  // Anything not matched below
    case (opcode)
      OPC_OP: begin
        if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000: op = OP_ADD;
            3'b001: op = OP_SLL;
            3'b010: op = OP_SLT;
            3'b011: op = OP_SLTU;
            3'b100: op = OP_XOR;
            3'b101: op = OP_SRL;
            3'b110: op = OP_OR;
            default: op = OP_AND;
          endcase
        end else if (funct7 == 7'b0100000) begin
          if (funct3 == 3'b000) op = OP_SUB;
          else if (funct3 == 3'b101) op = OP_SRA;
        end else if (funct7 == 7'b0000001) begin
          // RV32M, all eight funct3 values used
          op = rv_op_e'(8'(OP_MUL) + 8'(funct3));
        end
      end
      OPC_OP_IMM: begin
        case (funct3)
          3'b000: op = OP_ADDI;
          3'b010: op = OP_SLTI;
          3'b011: op = OP_SLTIU;
          3'b100: op = OP_XORI;
          3'b110: op = OP_ORI;
          3'b111: op = OP_ANDI;
          3'b001: if (funct7 == 7'b0000000) op = OP_SLLI;
          default: begin
            if (funct7 == 7'b0000000) op = OP_SRLI;
            else if (funct7 == 7'b0100000) op = OP_SRAI;
          end
        endcase
      end
      OPC_LOAD: begin
        case (funct3)
          3'b000: op = OP_LB;
          3'b001: op = OP_LH;
          3'b010: op = OP_LW;
          3'b100: op = OP_LBU;
          3'b101: op = OP_LHU;
          default: op = OP_ILLEGAL;
        endcase
      end
      OPC_STORE: begin
        if (funct3 == 3'b000) op = OP_SB;
        else if (funct3 == 3'b001) op = OP_SH;
        else if (funct3 == 3'b010) op = OP_SW;
      end
      OPC_BRANCH: begin
        case (funct3)
          3'b000: op = OP_BEQ;
          3'b001: op = OP_BNE;
          3'b100: op = OP_BLT;
          3'b101: op = OP_BGE;
          3'b110: op = OP_BLTU;
          3'b111: op = OP_BGEU;
          default: op = OP_ILLEGAL;
        endcase
      end
      OPC_JAL: op = OP_JAL;
      OPC_JALR: if (funct3 == 3'b000) op = OP_JALR;
      OPC_LUI: op = OP_LUI;
      OPC_AUIPC: op = OP_AUIPC;
      OPC_MISC_MEM: begin
        if (funct3 == 3'b000) op = OP_FENCE;
        else if (funct3 == 3'b001) op = OP_FENCE_I;
      end
      OPC_SYSTEM: begin
        case (funct3)
          3'b000: begin
            // Privileged ops share funct3, the immediate tells them apart
            if (imm12 == IMM_ECALL) op = OP_ECALL;
            else if (imm12 == IMM_EBREAK) op = OP_EBREAK;
            else if (imm12 == IMM_MRET) op = OP_MRET;
            else if (imm12 == IMM_WFI) op = OP_WFI;
          end
          3'b001: op = OP_CSRRW;
          3'b010: op = OP_CSRRS;
          3'b011: op = OP_CSRRC;
          3'b101: op = OP_CSRRWI;
          3'b110: op = OP_CSRRSI;
          3'b111: op = OP_CSRRCI;
          default: op = OP_ILLEGAL;
        endcase
      end
      default: op = OP_ILLEGAL;
    endcase
    return op;
  endfunction

  assign decoded_op = fetch.fault ? OP_FETCH_FAULT : decode(fetch.word);

  // Instruction register, loaded once per fetch
  always_ff @(posedge clk) begin
    if (fetch.capture) begin
      ir_word <= fetch.word;
      ir_pc <= fetch.pc;
      ir_op <= decoded_op;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) issue_valid <= 1'b0;
    else if (fetch.capture) issue_valid <= 1'b1;
    else if (issue_accept) issue_valid <= 1'b0;  // Held until execute takes it
  end

  assign issue_accept = issue_valid & issue_ready;

  assign issue = '{
    pc: ir_pc,
    word: ir_word,
    op: ir_op
  };

endmodule

`default_nettype wire

/* hw/fetch_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_ctrl (
  input wire logic clk,
  input wire logic rst,
  output rv_fetch_pkg::axil_ar_t ar,
  input wire logic arready,
  input wire rv_fetch_pkg::axil_r_t r,
  output logic rready,
  output rv_fetch_pkg::fetch_word_t fetch,
  input wire logic issue_accept,
  input wire rv_fetch_pkg::redirect_t redirect
);

  import rv_fetch_pkg::*;

  fetch_state_e state;
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] next_pc;
  logic ar_valid;
  logic ar_done;  // AR handshake on this edge
  logic r_done;  // R handshake on this edge

  assign ar_done = ar_valid & arready;
  assign r_done = rready & r.valid;

  // Sequential PC unless execute asks for a jump
  assign next_pc = redirect.taken ? redirect.target : pc + INSN_BYTES;

  assign ar = '{
    valid: ar_valid,
    addr: pc,
    prot: AR_PROT_INSN
  };

  assign fetch = '{
    capture: r_done,
    pc: pc,
    word: r.data,
    fault: (r.resp != RESP_OKAY)
  };

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= FETCH;
      pc <= RESET_PC;
      ar_valid <= 1'b0;
      rready <= 1'b0;
    end else begin
      case (state)
        FETCH: begin
          if (ar_valid) begin
            if (ar_done) begin
              ar_valid <= 1'b0;
              rready <= 1'b1;  // Address taken, wait for data
            end
          end else if (rready) begin
            if (r_done) begin
              rready <= 1'b0;
              state <= EXECUTE;  // Decoder holds the word now
            end
          end else begin
            ar_valid <= 1'b1;  // Only reached right after reset
          end
        end

        EXECUTE: begin
          // Execute stage owns the instruction until it accepts
          if (issue_accept) begin
            pc <= next_pc;
            ar_valid <= 1'b1;  // Next request starts immediately
            state <= FETCH;
          end
        end

        default: begin
          state <= FETCH;
          ar_valid <= 1'b0;
          rready <= 1'b0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/rv_fetch_pkg.sv */
`default_nettype none

package rv_fetch_pkg;

  localparam int XLEN = 32;
  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;
  localparam logic [XLEN-1:0] INSN_BYTES = 32'd4;  // PC step, no compressed ISA
  localparam logic [1:0] RESP_OKAY = 2'b00;
  localparam logic [2:0] AR_PROT_INSN = 3'b100;  // Instruction, secure, unprivileged

  // Major opcodes, bits [6:0]
  localparam logic [6:0] OPC_OP = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL = 7'b1101111;
  localparam logic [6:0] OPC_JALR = 7'b1100111;
  localparam logic [6:0] OPC_LUI = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC = 7'b0010111;
  localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // SYSTEM immediates with funct3 = 000
  localparam logic [11:0] IMM_ECALL = 12'h000;
  localparam logic [11:0] IMM_EBREAK = 12'h001;
  localparam logic [11:0] IMM_MRET = 12'h302;
  localparam logic [11:0] IMM_WFI = 12'h105;

  typedef enum logic [7:0] {
    OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
    OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
    OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
    OP_DIV, OP_DIVU, OP_REM, OP_REMU,
    OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
    OP_SLLI, OP_SRLI, OP_SRAI,
    OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
    OP_SB, OP_SH, OP_SW,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
    OP_JAL, OP_JALR, OP_LUI, OP_AUIPC,
    OP_CSRRW, OP_CSRRS, OP_CSRRC, OP_CSRRWI, OP_CSRRSI, OP_CSRRCI,
    OP_FENCE, OP_FENCE_I, OP_ECALL, OP_EBREAK, OP_MRET, OP_WFI,
    OP_FETCH_FAULT = 8'hFE,
    OP_ILLEGAL = 8'hFF
  } rv_op_e;

  typedef enum logic {
    FETCH,
    EXECUTE
  } fetch_state_e;

  typedef struct packed {
    logic valid;
    logic [XLEN-1:0] addr;
    logic [2:0] prot;
  } axil_ar_t;

  typedef struct packed {
    logic valid;
    logic [XLEN-1:0] data;
    logic [1:0] resp;
  } axil_r_t;

  typedef struct packed {
    logic capture;  // One-cycle pulse on the R handshake
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] word;
    logic fault;  // Response was not OKAY
  } fetch_word_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] word;
    rv_op_e op;
  } issue_t;

  typedef struct packed {
    logic taken;
    logic [XLEN-1:0] target;
  } redirect_t;

endpackage

`default_nettype wire
